/* common/layer_pkg.sv */
// layer_pkg: geometry, index types and MAC control word of the conv layer
package layer_pkg;

    // input frame length
    localparam int X_LEN = 32;

    // filter taps
    localparam int F_LEN = 9;

    // output points per frame
    localparam int Y_LEN = X_LEN - F_LEN + 1;

    // input memory address
    typedef logic [4:0] x_addr_t;

    // tap index
    typedef logic [3:0] f_addr_t;

    // MAC strobes
    typedef struct packed {
        logic clear;
        logic enable;
    } mac_ctrl_t;

endpackage

/* common/num_pkg.sv */
// num_pkg: fixed-point sample type and saturation limits for the datapath
package num_pkg;

    // word width of samples, coefficients, products and sums
    localparam int SAMPLE_W = 16;

    // signed fixed-point word
    typedef logic signed [SAMPLE_W-1:0] sample_t;

    // largest representable value, 32767
    localparam sample_t SAT_MAX = {1'b0, {(SAMPLE_W-1){1'b1}}};

    // smallest representable value, -32768
    localparam sample_t SAT_MIN = {1'b1, {(SAMPLE_W-1){1'b0}}};

    // clamp a wide signed value into sample_t range
    function automatic sample_t saturate(input logic signed [2*SAMPLE_W-1:0] value);
        sample_t result;
        if (value > SAT_MAX) begin
            result = SAT_MAX;
        end else if (value < SAT_MIN) begin
            result = SAT_MIN;
        end else begin
            result = value[SAMPLE_W-1:0];
        end
        return result;
    endfunction

endpackage

/* conv_layer/conv_control.sv */
// conv_control: frame sequencer for sample loading, tap stepping and pass counting
`timescale 1ns/100ps

module conv_control
    import layer_pkg::*;
#(
    parameter int LANES  = 3,
    parameter int PASSES = 8,
    localparam int PASS_W = $clog2(PASSES)
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              x_valid_i,
    output logic              x_ready_o,
    output logic              x_we_o,
    output x_addr_t           x_addr_o,
    output f_addr_t           tap_o,
    output mac_ctrl_t         mac_ctrl_o,
    output logic [PASS_W-1:0] pass_o,
    input  logic              mac_done_i,
    output logic              frame_ready_o,
    input  logic              drain_done_i
);

    typedef enum logic [1:0] {
        LOAD,
        COMPUTE,
        WAIT_MAC,
        DRAIN
    } state_t;

    state_t            state;
    x_addr_t           load_cnt;
    f_addr_t           tap_cnt;
    logic [PASS_W-1:0] pass_cnt;
    logic              accept;
    logic              last_pass;

    assign accept    = x_valid_i && x_ready_o;
    assign last_pass = (pass_cnt == PASS_W'(PASSES - 1));

    assign x_ready_o = (state == LOAD);
    assign x_we_o    = accept;
    // tap index doubles as the read offset while computing
    assign x_addr_o  = (state == COMPUTE) ? x_addr_t'(tap_cnt) : load_cnt;
    assign tap_o     = tap_cnt;
    assign pass_o    = pass_cnt;

    assign frame_ready_o = (state == WAIT_MAC) && mac_done_i && last_pass;

    always_comb begin
        mac_ctrl_o.enable = (state == COMPUTE);
        // accumulator held at zero while loading, cleared after each pass
        mac_ctrl_o.clear  = (state == LOAD) || ((state == WAIT_MAC) && mac_done_i);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= LOAD;
            load_cnt <= '0;
            tap_cnt  <= '0;
            pass_cnt <= '0;
        end else begin
            unique case (state)
                LOAD: begin
                    if (accept) begin
                        load_cnt <= load_cnt + 1'b1;
                        if (load_cnt == x_addr_t'(X_LEN - 1)) begin
                            state <= COMPUTE;
                        end
                    end
                end
                COMPUTE: begin
                    if (tap_cnt == f_addr_t'(F_LEN - 1)) begin
                        tap_cnt <= '0;
                        state   <= WAIT_MAC;
                    end else begin
                        tap_cnt <= tap_cnt + 1'b1;
                    end
                end
                WAIT_MAC: begin
                    if (mac_done_i) begin
                        if (last_pass) begin
                            pass_cnt <= '0;
                            state    <= DRAIN;
                        end else begin
                            pass_cnt <= pass_cnt + 1'b1;
                            state    <= COMPUTE;
                        end
                    end
                end
                DRAIN: begin
                    if (drain_done_i) begin
                        state <= LOAD;
                    end
                end
                default: state <= LOAD;
            endcase
        end
    end

endmodule

/* conv_layer/conv_lane.sv */
// conv_lane: one compute lane with input memory, saturating MAC, ReLU and result memory
`timescale 1ns/100ps

module conv_lane
    import num_pkg::*;
    import layer_pkg::*;
#(
    parameter int LANES  = 3,
    parameter int PASSES = 8,
    localparam int PASS_W = $clog2(PASSES)
) (
    input  logic              clk,
    input  logic              reset,
    input  x_addr_t           lane_base_i,
    input  sample_t           x_data_i,
    input  logic              x_we_i,
    input  x_addr_t           x_addr_i,
    input  sample_t           coef_i,
    input  mac_ctrl_t         mac_ctrl_i,
    input  logic [PASS_W-1:0] pass_i,
    output logic              mac_done_o,
    input  logic [PASS_W-1:0] rd_addr_i,
    output sample_t           rd_data_o
);

    x_addr_t           rd_x_addr;
    x_addr_t           x_mem_addr;
    sample_t           x_rdata;
    sample_t           acc;
    sample_t           relu;
    logic              enable_q;
    mac_ctrl_t         mac_ctrl_d;
    logic [PASS_W-1:0] y_mem_addr;

    // point index of this lane plus tap offset
    assign rd_x_addr  = x_addr_t'(pass_i * LANES) + lane_base_i + x_addr_i;
    assign x_mem_addr = x_we_i ? x_addr_i : rd_x_addr;

    sample_ram #(.DEPTH(X_LEN)) u_x_mem (
        .clk     (clk),
        .we_i    (x_we_i),
        .addr_i  (x_mem_addr),
        .wdata_i (x_data_i),
        .rdata_o (x_rdata)
    );

    // enable follows the memory and ROM read latency
    always_ff @(posedge clk) begin
        if (reset) begin
            enable_q <= 1'b0;
        end else begin
            enable_q <= mac_ctrl_i.enable;
        end
    end

    always_comb begin
        mac_ctrl_d        = mac_ctrl_i;
        mac_ctrl_d.enable = enable_q;
    end

    sat_mac u_mac (
        .clk    (clk),
        .reset  (reset),
        .ctrl_i (mac_ctrl_d),
        .a_i    (x_rdata),
        .b_i    (coef_i),
        .acc_o  (acc),
        .done_o (mac_done_o)
    );

    // ReLU on the way into the result memory
    assign relu       = acc[SAMPLE_W-1] ? '0 : acc;
    assign y_mem_addr = mac_done_o ? pass_i : rd_addr_i;

    sample_ram #(.DEPTH(PASSES)) u_y_mem (
        .clk     (clk),
        .we_i    (mac_done_o),
        .addr_i  (y_mem_addr),
        .wdata_i (relu),
        .rdata_o (rd_data_o)
    );

endmodule

/* conv_layer/conv_layer.sv */
// conv_layer: 1-D convolution layer with parallel saturating MAC lanes and ReLU
`timescale 1ns/100ps

module conv_layer
    import num_pkg::*;
    import layer_pkg::*;
#(
    parameter int LANES = 3
) (
    input  logic    clk,
    input  logic    reset,
    input  sample_t x_data_i,
    input  logic    x_valid_i,
    output logic    x_ready_o,
    output sample_t y_data_o,
    output logic    y_valid_o,
    input  logic    y_ready_i
);

    // passes needed to cover every output point
    localparam int PASSES = (Y_LEN + LANES - 1) / LANES;
    localparam int PASS_W = $clog2(PASSES);

    logic                    x_we;
    x_addr_t                 x_addr;
    f_addr_t                 tap;
    mac_ctrl_t               mac_ctrl;
    logic [PASS_W-1:0]       pass;
    logic [PASS_W-1:0]       rd_addr;
    sample_t                 coef;
    logic [LANES-1:0]        lane_done;
    sample_t [LANES-1:0]     lane_data;
    logic                    frame_ready;
    logic                    drain_done;

    conv_control #(
        .LANES  (LANES),
        .PASSES (PASSES)
    ) u_control (
        .clk           (clk),
        .reset         (reset),
        .x_valid_i     (x_valid_i),
        .x_ready_o     (x_ready_o),
        .x_we_o        (x_we),
        .x_addr_o      (x_addr),
        .tap_o         (tap),
        .mac_ctrl_o    (mac_ctrl),
        .pass_o        (pass),
        .mac_done_i    (&lane_done),
        .frame_ready_o (frame_ready),
        .drain_done_i  (drain_done)
    );

    filter_rom u_filter_rom (
        .clk    (clk),
        .addr_i (tap),
        .coef_o (coef)
    );

    // lane i computes points pass*LANES + i
    for (genvar i = 0; i < LANES; i++) begin : g_lane
        conv_lane #(
            .LANES  (LANES),
            .PASSES (PASSES)
        ) u_lane (
            .clk         (clk),
            .reset       (reset),
            .lane_base_i (x_addr_t'(i)),
            .x_data_i    (x_data_i),
            .x_we_i      (x_we),
            .x_addr_i    (x_addr),
            .coef_i      (coef),
            .mac_ctrl_i  (mac_ctrl),
            .pass_i      (pass),
            .mac_done_o  (lane_done[i]),
            .rd_addr_i   (rd_addr),
            .rd_data_o   (lane_data[i])
        );
    end

    output_drain #(
        .LANES  (LANES),
        .PASSES (PASSES)
    ) u_drain (
        .clk           (clk),
        .reset         (reset),
        .frame_ready_i (frame_ready),
        .rd_addr_o     (rd_addr),
        .lane_data_i   (lane_data),
        .y_data_o      (y_data_o),
        .y_valid_o     (y_valid_o),
        .y_ready_i     (y_ready_i),
        .drain_done_o  (drain_done)
    );

endmodule

/* conv_layer/output_drain.sv */
// output_drain: streams stored lane results out in point order under valid/ready
`timescale 1ns/100ps

module output_drain
    import num_pkg::*;
    import layer_pkg::*;
#(
    parameter int LANES  = 3,
    parameter int PASSES = 8,
    localparam int PASS_W = $clog2(PASSES),
    localparam int LANE_W = (LANES > 1) ? $clog2(LANES) : 1
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                frame_ready_i,
    output logic [PASS_W-1:0]   rd_addr_o,
    input  sample_t [LANES-1:0] lane_data_i,
    output sample_t             y_data_o,
    output logic                y_valid_o,
    input  logic                y_ready_i,
    output logic                drain_done_o
);

    logic [LANE_W-1:0]        lane_sel;
    logic [$clog2(Y_LEN)-1:0] point;
    logic                     fetch;
    logic                     accept;
    logic                     last_point;

    assign accept       = y_valid_o && y_ready_i;
    assign last_point   = (point == ($clog2(Y_LEN))'(Y_LEN - 1));
    assign drain_done_o = accept && last_point;
    assign y_data_o     = lane_data_i[lane_sel];

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_addr_o <= '0;
            lane_sel  <= '0;
            point     <= '0;
            fetch     <= 1'b0;
            y_valid_o <= 1'b0;
        end else if (frame_ready_i) begin
            rd_addr_o <= '0;
            lane_sel  <= '0;
            point     <= '0;
            fetch     <= 1'b1;
        end else if (fetch) begin
            // address presented last cycle, data now registered
            fetch     <= 1'b0;
            y_valid_o <= 1'b1;
        end else if (accept) begin
            y_valid_o <= 1'b0;
            if (!last_point) begin
                point <= point + 1'b1;
                fetch <= 1'b1;
                if (lane_sel == LANE_W'(LANES - 1)) begin
                    lane_sel  <= '0;
                    rd_addr_o <= rd_addr_o + 1'b1;
                end else begin
                    lane_sel <= lane_sel + 1'b1;
                end
            end
        end
    end

endmodule

/* logic/filter_rom.sv */
// filter_rom: registered table of the nine filter coefficients
`timescale 1ns/100ps

module filter_rom
    import num_pkg::*;
    import layer_pkg::*;
(
    input  logic    clk,
    input  f_addr_t addr_i,
    output sample_t coef_o
);

    always_ff @(posedge clk) begin
        case (addr_i)
            4'd0:    coef_o <= -16'sd5;
            4'd1:    coef_o <= -16'sd4;
            4'd2:    coef_o <= -16'sd6;
            4'd3:    coef_o <= -16'sd1;
            4'd4:    coef_o <= 16'sd4;
            4'd5:    coef_o <= 16'sd5;
            4'd6:    coef_o <= 16'sd4;
            4'd7:    coef_o <= -16'sd5;
            4'd8:    coef_o <= -16'sd4;
            // unused tap slots read as zero
            default: coef_o <= '0;
        endcase
    end

endmodule

/* logic/sample_ram.sv */
// sample_ram: single-port sample memory with registered read, read before write
`timescale 1ns/100ps

module sample_ram
    import num_pkg::*;
#(
    parameter int DEPTH = 32,
    localparam int ADDR_W = $clog2(DEPTH)
) (
    input  logic              clk,
    input  logic              we_i,
    input  logic [ADDR_W-1:0] addr_i,
    input  sample_t           wdata_i,
    output sample_t           rdata_o
);

    sample_t mem [DEPTH];

    always_ff @(posedge clk) begin
        rdata_o <= mem[addr_i];
        if (we_i) begin
            mem[addr_i] <= wdata_i;
        end
    end

endmodule

/* logic/sat_mac.sv */
// sat_mac: three-stage multiply-accumulate with saturation on product and sum
`timescale 1ns/100ps

module sat_mac
    import num_pkg::*;
    import layer_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  mac_ctrl_t ctrl_i,
    input  sample_t   a_i,
    input  sample_t   b_i,
    output sample_t   acc_o,
    output logic      done_o
);

    sample_t                      a_q;
    sample_t                      b_q;
    sample_t                      prod_q;
    logic                         op_valid;
    logic                         prod_valid;
    logic signed [2*SAMPLE_W-1:0] prod_full;
    logic signed [2*SAMPLE_W-1:0] sum_full;
    sample_t                      prod_sat;
    sample_t                      sum_sat;

    always_comb begin
        prod_full = a_q * b_q;
        prod_sat  = saturate(prod_full);
        // sum is clamped again after the clamped product is added
        sum_full  = acc_o + prod_q;
        sum_sat   = saturate(sum_full);
    end

    // stage valid flags
    always_ff @(posedge clk) begin
        if (reset) begin
            op_valid   <= 1'b0;
            prod_valid <= 1'b0;
            done_o     <= 1'b0;
        end else begin
            op_valid   <= ctrl_i.enable;
            prod_valid <= op_valid;
            // last pair of a burst reaches the accumulator
            done_o     <= prod_valid && !op_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl_i.enable) begin
            a_q <= a_i;
            b_q <= b_i;
        end
        if (op_valid) begin
            prod_q <= prod_sat;
        end
        if (ctrl_i.clear) begin
            acc_o <= '0;
        end else if (prod_valid) begin
            acc_o <= sum_sat;
        end
    end

endmodule

/* verification/conv_cases.txt */
// per case: two lines of 16 input samples (x[0] to x[31], hex)
// then two lines of 12 expected outputs (y[0] to y[23], hex, after ReLU)

// descending ramp, x[i] = -i, y[k] = 12k + 21
0000 FFFF FFFE FFFD FFFC FFFB FFFA FFF9 FFF8 FFF7 FFF6 FFF5 FFF4 FFF3 FFF2 FFF1
FFF0 FFEF FFEE FFED FFEC FFEB FFEA FFE9 FFE8 FFE7 FFE6 FFE5 FFE4 FFE3 FFE2 FFE1
0015 0021 002D 0039 0045 0051 005D 0069 0075 0081 008D 0099
00A5 00B1 00BD 00C9 00D5 00E1 00ED 00F9 0105 0111 011D 0129

// impulses, x[12] = 10000 saturates products, x[20] = 100 does not
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 2710 0000 0000 0000
0000 0000 0000 0000 0064 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 7FFF 7FFF 7FFF 0000 0000 0000
0000 0000 0190 01F4 0190 0000 0000 0000 0000 0000 0000 0000

// full-scale negative, product and sum clamping
8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000
8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000
7FFE 7FFE 7FFE 7FFE 7FFE 7FFE 7FFE 7FFE 7FFE 7FFE 7FFE 7FFE
7FFE 7FFE 7FFE 7FFE 7FFE 7FFE 7FFE 7FFE 7FFE 7FFE 7FFE 7FFE

// full-scale positive, clamped sum ends negative
7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF
7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000

// constant -1, y = -(sum of taps) = 12
FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF
FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF
000C 000C 000C 000C 000C 000C 000C 000C 000C 000C 000C 000C
000C 000C 000C 000C 000C 000C 000C 000C 000C 000C 000C 000C

/* verification/conv_layer_tb.sv */
// conv_layer_tb: drives input frames from the case file and checks the streamed results
`timescale 1ns/100ps

module conv_layer_tb;

    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DELAY  = 2;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_CASES    = 5;
    localparam int X_WORDS      = 32;
    localparam int Y_POINTS     = 24;
    localparam int CASE_WORDS   = X_WORDS + Y_POINTS;
    localparam int TIMEOUT_NS   = NUM_CASES * 3000 * CLK_PERIOD;
    localparam logic [31:0] SEED = 32'd59541;

    logic        clk;
    logic        reset;
    logic [15:0] x_data;
    logic        x_valid;
    logic        x_ready;
    logic [15:0] y_data;
    logic        y_valid;
    logic        y_ready;
    logic [31:0] lcg_state;

    // per case: 32 input words, then 24 expected outputs
    logic [15:0] case_mem [0:NUM_CASES*CASE_WORDS-1];

    tb_clock #(.PERIOD(CLK_PERIOD)) u_clock (
        .clk_o (clk)
    );

    conv_layer #(.LANES(3)) uut (
        .clk       (clk),
        .reset     (reset),
        .x_data_i  (x_data),
        .x_valid_i (x_valid),
        .x_ready_o (x_ready),
        .y_data_o  (y_data),
        .y_valid_o (y_valid),
        .y_ready_i (y_ready)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAIL %s: got 0x%0h, expected 0x%0h at %0t", name, actual, expected,
                     $time);
            $display("TEST RESULT: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // feed one frame with random gaps in x_valid
    task automatic load_frame(input int c);
        int   idx;
        int   base;
        logic accepted;
        idx  = 0;
        base = c * CASE_WORDS;
        while (idx < X_WORDS) begin
            lcg_state = lcg_next(lcg_state);
            x_valid   = (lcg_state[21:20] != 2'b00);
            x_data    = case_mem[base+idx];
            @(negedge clk);
            check_value("x_ready_o", x_ready, 1);
            accepted = x_valid && x_ready;
            @(posedge clk);
            #DRIVE_DELAY;
            if (accepted) begin
                idx++;
            end
        end
        x_valid = 1'b0;
        x_data  = '0;
        // frame full, port closes until the drain is over
        @(negedge clk);
        check_value("x_ready_o", x_ready, 0);
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    // accept 24 results under random back-pressure
    task automatic collect_results(input int c);
        int          count;
        int          base;
        logic        holding;
        logic [15:0] held;
        count   = 0;
        base    = c * CASE_WORDS + X_WORDS;
        holding = 1'b0;
        held    = '0;
        while (count < Y_POINTS) begin
            lcg_state = lcg_next(lcg_state);
            y_ready   = lcg_state[20];
            @(negedge clk);
            check_value("x_ready_o", x_ready, 0);
            if (holding) begin
                // stalled result must not move
                check_value("y_valid_o", y_valid, 1);
                check_value("y_data_o", y_data, held);
            end
            if (y_valid && y_ready) begin
                check_value($sformatf("y_data_o[case %0d point %0d]", c, count),
                            y_data, case_mem[base+count]);
                count++;
                holding = 1'b0;
            end else if (y_valid) begin
                holding = 1'b1;
                held    = y_data;
            end
            @(posedge clk);
            #DRIVE_DELAY;
        end
        y_ready = 1'b0;
        @(negedge clk);
        check_value("x_ready_o", x_ready, 1);
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    initial begin
        reset     = 1'b1;
        x_data    = '0;
        x_valid   = 1'b0;
        y_ready   = 1'b0;
        lcg_state = SEED;
        $readmemh("verification/conv_cases.txt", case_mem);

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        @(negedge clk);
        check_value("x_ready_o", x_ready, 1);
        check_value("y_valid_o", y_valid, 0);
        @(posedge clk);
        #DRIVE_DELAY;

        for (int c = 0; c < NUM_CASES; c++) begin
            load_frame(c);
            collect_results(c);
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

    // generous bound per case
    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns, the DUT stopped making progress",
                 TIMEOUT_NS);
        $display("TEST RESULT: FAIL");
        $fatal(1, "timeout");
    end

endmodule

/* verification/tb_clock.sv */
// tb_clock: free-running testbench clock source
`timescale 1ns/100ps

module tb_clock #(
    parameter int PERIOD = 40
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    // half period high, half period low
    always begin
        #(PERIOD / 2) clk_o = ~clk_o;
    end

endmodule

/* verilog.f */
common/num_pkg.sv
common/layer_pkg.sv
logic/sample_ram.sv
logic/sat_mac.sv
logic/filter_rom.sv
conv_layer/conv_control.sv
conv_layer/conv_lane.sv
conv_layer/output_drain.sv
conv_layer/conv_layer.sv
verification/tb_clock.sv
verification/conv_layer_tb.sv
